//--- qpimem_pkg.sv
// shared constants for the qpi psram subsystem
// chip command set, data widths and fifo sizing
// host request, data word and read item structs
`default_nettype none

package qpimem_pkg;

	// word address, six nibbles on the bus
	localparam int addr_w = 24;
	// data word, eight nibbles on the bus
	localparam int word_w = 32;

	// burst length limits
	localparam int max_burst = 16;
	// holds 0 up to max_burst
	localparam int count_w = $clog2(max_burst + 1);

	// both fifos hold one full burst
	localparam int fifo_depth = max_burst;

	// ly68l6400 style command set, commands sent as qpi nibbles
	localparam logic [7:0] read_cmd = 8'heb;
	localparam logic [7:0] write_cmd = 8'h38;

	// dummy nibbles after the address
	localparam int read_dummy = 7;
	localparam int write_dummy = 0;
	// value put on the bus during dummies
	localparam logic [3:0] dummy_val = 4'h0;

	typedef logic [word_w-1:0] word_t;

	// one burst request from the host
	typedef struct packed {
		logic write;
		logic [addr_w-1:0] addr;
		// 1 to max_burst
		logic [count_w-1:0] nwords;
	} host_req_t;

	// read fifo entry, last marks the final word of a burst
	typedef struct packed {
		word_t data;
		logic last;
	} rd_item_t;

endpackage

`default_nettype wire

//--- qpimem_fifo.sv
// synchronous fifo, payload type and depth set per instance
// circular buffer with occupancy count, head shown combinationally
`default_nettype none
`timescale 1ns/100ps

module qpimem_fifo #(
	parameter type payload_t = qpimem_pkg::word_t,
	// power of two, pointers wrap on their own
	parameter int depth = qpimem_pkg::fifo_depth
) (
	input wire clk,
	input wire rst,
	input wire push,
	input wire payload_t push_data,
	input wire pop,
	output payload_t head,
	output logic full,
	output logic empty,
	output logic [qpimem_pkg::count_w:0] count
);

	payload_t mem [depth];
	logic [$clog2(depth)-1:0] wr_ptr;
	logic [$clog2(depth)-1:0] rd_ptr;
	logic push_ok;
	logic pop_ok;

	// push when full and pop when empty are ignored
	assign push_ok = push && !full;
	assign pop_ok = pop && !empty;

	assign full = (count == depth);
	assign empty = (count == 0);
	assign head = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push_ok)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop_ok)
				rd_ptr <= rd_ptr + 1'b1;
			// occupancy only moves when one side acts alone
			case ({push_ok, pop_ok})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- qpimem_iface.sv
// qpi bit engine for a psram already switched to qpi mode
// sends command, address, dummy and data nibbles, samples read nibbles
// spi_clk is the inverted system clock
`default_nettype none
`timescale 1ns/100ps

module qpimem_iface (
	input wire clk,
	input wire rst,
	input wire do_read,
	input wire do_write,
	output logic next_byte,
	input wire [qpimem_pkg::addr_w-1:0] addr,
	input wire qpimem_pkg::word_t wdata,
	output qpimem_pkg::word_t rdata,
	output logic is_idle,
	output logic spi_clk,
	output logic spi_cs,
	output logic [3:0] spi_sout,
	input wire [3:0] spi_sin,
	output logic spi_oe
);

	typedef enum logic [2:0] {
		st_idle,
		st_cmd,
		st_addr,
		st_dummy,
		st_data,
		st_release
	} state_t;

	state_t state;
	// nibble index within the current phase, counts down
	logic [3:0] nib;
	// direction latched at burst start
	logic cur_read;
	// write level taken with next_byte
	logic keep_more;
	// read nibble taken on the falling clk edge
	logic [3:0] sin_s;
	// outgoing word on writes, assembly register on reads
	qpimem_pkg::word_t shift_word;
	logic [7:0] cmd;

	// pins change on rising clk, chip samples on rising spi_clk
	assign spi_clk = ~clk;

	assign is_idle = (state == st_idle) && !do_read && !do_write;

	assign cmd = cur_read ? qpimem_pkg::read_cmd : qpimem_pkg::write_cmd;

	// chip drives on falling spi_clk, so mid cycle is safe here
	always_ff @(negedge clk) begin
		sin_s <= spi_sin;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
			nib <= '0;
			cur_read <= 1'b0;
			keep_more <= 1'b0;
			next_byte <= 1'b0;
			spi_cs <= 1'b1;
			spi_oe <= 1'b0;
			spi_sout <= '0;
		end else begin
			next_byte <= 1'b0;
			// level sampled together with each word handover
			if (next_byte)
				keep_more <= do_write;

			case (state)
				st_idle: begin
					if (do_read || do_write) begin
						state <= st_cmd;
						nib <= 4'd1;
						cur_read <= do_read;
					end
				end

				st_cmd: begin
					// cs low together with the first command nibble
					spi_cs <= 1'b0;
					spi_oe <= 1'b1;
					spi_sout <= cmd[nib*4 +: 4];
					nib <= nib - 1'b1;
					if (nib == 4'd0) begin
						state <= st_addr;
						nib <= 4'd5;
					end
				end

				st_addr: begin
					// high nibble first
					spi_sout <= addr[nib*4 +: 4];
					nib <= nib - 1'b1;
					if (nib == 4'd0) begin
						if (!cur_read && qpimem_pkg::write_dummy == 0) begin
							// first word taken here, no dummies on writes
							shift_word <= wdata;
							next_byte <= 1'b1;
							state <= st_data;
							nib <= 4'd7;
						end else begin
							state <= st_dummy;
							nib <= cur_read ? 4'(qpimem_pkg::read_dummy) :
								4'(qpimem_pkg::write_dummy);
						end
					end
				end

				st_dummy: begin
					spi_sout <= qpimem_pkg::dummy_val;
					nib <= nib - 1'b1;
					if (cur_read) begin
						// turnaround in the last dummy nibble
						if (nib == 4'd1)
							spi_oe <= 1'b0;
						// extra cycle lines the sample up with the pins
						if (nib == 4'd0) begin
							state <= st_data;
							nib <= 4'd7;
						end
					end else if (nib == 4'd1) begin
						shift_word <= wdata;
						next_byte <= 1'b1;
						state <= st_data;
						nib <= 4'd7;
					end
				end

				st_data: begin
					nib <= nib - 1'b1;
					if (cur_read) begin
						shift_word <= {shift_word[27:0], sin_s};
						if (nib == 4'd0) begin
							rdata <= {shift_word[27:0], sin_s};
							next_byte <= 1'b1;
							nib <= 4'd7;
							// host dropped the level, this was the last word
							if (!do_read) begin
								spi_cs <= 1'b1;
								state <= st_release;
							end
						end
					end else begin
						spi_sout <= shift_word[31:28];
						shift_word <= {shift_word[27:0], 4'h0};
						if (nib == 4'd0) begin
							if (keep_more) begin
								// chain the next word straight on
								shift_word <= wdata;
								next_byte <= 1'b1;
								nib <= 4'd7;
							end else begin
								state <= st_release;
							end
						end
					end
				end

				st_release: begin
					// last write nibble is on the pins now
					spi_cs <= 1'b1;
					spi_oe <= 1'b0;
					state <= st_idle;
				end

				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- qpimem_sequencer.sv
// burst sequencer between host, fifos and the qpi engine
// admits a request once the fifos can serve the whole burst
// shapes the do levels and turns next_byte into fifo pops and pushes
`default_nettype none
`timescale 1ns/100ps

module qpimem_sequencer (
	input wire clk,
	input wire rst,
	input wire req_strobe,
	input wire qpimem_pkg::host_req_t req,
	output logic ready,
	output logic done,
	input wire [qpimem_pkg::count_w:0] wr_count,
	input wire [qpimem_pkg::count_w:0] rd_count,
	output logic wr_pop,
	output logic rd_push,
	output qpimem_pkg::rd_item_t rd_push_item,
	output logic do_read,
	output logic do_write,
	output logic [qpimem_pkg::addr_w-1:0] addr,
	input wire next_byte,
	input wire qpimem_pkg::word_t rdata,
	input wire is_idle
);

	typedef enum logic [1:0] {
		sq_idle,
		sq_wait,
		sq_run
	} seq_state_t;

	seq_state_t state;
	// request held from strobe until done
	qpimem_pkg::host_req_t pend;
	// request under admission check
	qpimem_pkg::host_req_t cand;
	// words still to move in this burst
	logic [qpimem_pkg::count_w-1:0] left;
	logic [qpimem_pkg::count_w-1:0] left_after;
	logic [qpimem_pkg::count_w:0] rd_free;
	logic fits;
	logic wr_on;

	assign ready = (state == sq_idle);
	assign addr = pend.addr;

	// new strobe checked at once, a held one every cycle after
	assign cand = (state == sq_idle) ? req : pend;
	assign rd_free = qpimem_pkg::fifo_depth[qpimem_pkg::count_w:0] - rd_count;
	assign fits = cand.write ? (wr_count >= {1'b0, cand.nwords}) :
		(rd_free >= {1'b0, cand.nwords});

	assign left_after = next_byte ? left - 1'b1 : left;

	// write fifo head is taken by the engine on next_byte
	assign wr_pop = (state == sq_run) && next_byte && pend.write;
	assign rd_push = (state == sq_run) && next_byte && !pend.write;
	assign rd_push_item = '{data: rdata, last: (left == 1)};

	// low already in the cycle the final word is handed over
	assign do_write = wr_on && !(next_byte && left == 1);

	always_ff @(posedge clk) begin
		if (state == sq_idle && req_strobe)
			pend <= req;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= sq_idle;
			left <= '0;
			do_read <= 1'b0;
			wr_on <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			case (state)
				sq_idle, sq_wait: begin
					if ((state == sq_wait || req_strobe) && fits) begin
						state <= sq_run;
						left <= cand.nwords;
						do_read <= !cand.write;
						wr_on <= cand.write;
					end else if (req_strobe) begin
						// no room or data yet, keep ready low
						state <= sq_wait;
					end
				end

				sq_run: begin
					left <= left_after;
					if (next_byte && left == 1)
						wr_on <= 1'b0;
					// engine stops at the word end where do_read is low
					do_read <= do_read && (left_after > 1);
					if (is_idle) begin
						done <= 1'b1;
						state <= sq_idle;
					end
				end

				default: begin
					state <= sq_idle;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- qpimem_subsys.sv
// top level of the qpi psram access subsystem
// sequencer, qpi engine, write fifo and read fifo
`default_nettype none
`timescale 1ns/100ps

module qpimem_subsys (
	input wire clk,
	input wire rst,
	// host request
	input wire req_strobe,
	input wire qpimem_pkg::host_req_t req,
	output logic ready,
	output logic done,
	// host write data
	input wire wr_push,
	input wire qpimem_pkg::word_t wr_data,
	output logic wr_full,
	// host read data
	input wire rd_pop,
	output qpimem_pkg::rd_item_t rd_item,
	output logic rd_empty,
	// psram pins
	output logic spi_clk,
	output logic spi_cs,
	output logic [3:0] spi_sout,
	input wire [3:0] spi_sin,
	output logic spi_oe
);

	qpimem_pkg::word_t wr_head;
	logic [qpimem_pkg::count_w:0] wr_count;
	logic [qpimem_pkg::count_w:0] rd_count;
	logic wr_pop;
	logic rd_push;
	qpimem_pkg::rd_item_t rd_push_item;
	// sequencer to engine
	logic do_read;
	logic do_write;
	logic [qpimem_pkg::addr_w-1:0] addr;
	logic next_byte;
	qpimem_pkg::word_t rdata;
	logic is_idle;

	qpimem_fifo #(
		.payload_t(qpimem_pkg::word_t),
		.depth(qpimem_pkg::fifo_depth)
	) i_wr_fifo (
		.clk(clk),
		.rst(rst),
		.push(wr_push),
		.push_data(wr_data),
		.pop(wr_pop),
		.head(wr_head),
		.full(wr_full),
		.empty(),
		.count(wr_count)
	);

	qpimem_fifo #(
		.payload_t(qpimem_pkg::rd_item_t),
		.depth(qpimem_pkg::fifo_depth)
	) i_rd_fifo (
		.clk(clk),
		.rst(rst),
		.push(rd_push),
		.push_data(rd_push_item),
		.pop(rd_pop),
		.head(rd_item),
		.full(),
		.empty(rd_empty),
		.count(rd_count)
	);

	qpimem_sequencer i_sequencer (
		.clk(clk),
		.rst(rst),
		.req_strobe(req_strobe),
		.req(req),
		.ready(ready),
		.done(done),
		.wr_count(wr_count),
		.rd_count(rd_count),
		.wr_pop(wr_pop),
		.rd_push(rd_push),
		.rd_push_item(rd_push_item),
		.do_read(do_read),
		.do_write(do_write),
		.addr(addr),
		.next_byte(next_byte),
		.rdata(rdata),
		.is_idle(is_idle)
	);

	// write data comes straight from the fifo head
	qpimem_iface i_iface (
		.clk(clk),
		.rst(rst),
		.do_read(do_read),
		.do_write(do_write),
		.next_byte(next_byte),
		.addr(addr),
		.wdata(wr_head),
		.rdata(rdata),
		.is_idle(is_idle),
		.spi_clk(spi_clk),
		.spi_cs(spi_cs),
		.spi_sout(spi_sout),
		.spi_sin(spi_sin),
		.spi_oe(spi_oe)
	);

endmodule

`default_nettype wire

//--- qpi_psram_model.sv
// behavioural qpi psram for the testbench
// decodes command, address and dummies, stores and returns 32-bit words
// protocol checks on command, spi_oe and chip select length
`default_nettype none
`timescale 1ns/100ps

module qpi_psram_model (
	input wire spi_clk,
	input wire spi_cs,
	input wire [3:0] spi_sout,
	input wire spi_oe,
	output logic [3:0] spi_sin,
	output int errors
);

	// command plus address nibbles
	localparam int hdr_nibs = 8;
	// index of the first read data nibble
	localparam int rd_start = hdr_nibs + qpimem_pkg::read_dummy;

	logic [31:0] mem [256];
	// rising spi_clk edges seen with cs low
	int cnt;
	int data_nibs;
	int rd_pos;
	logic [7:0] cmd_sr;
	logic [23:0] addr_sr;
	logic [31:0] wr_sr;
	logic [31:0] rd_word;
	logic [7:0] wr_idx;
	logic [7:0] rd_idx;
	logic is_read;

	initial begin
		cnt = 0;
		errors = 0;
		is_read = 1'b0;
		spi_sin = 4'h0;
		// fill depends on every address bit
		for (int i = 0; i < 256; i++)
			mem[i] = 32'(i) * 32'h9e37_79b9;
	end

	// chip samples on rising spi_clk, pins settled half a cycle before
	always @(posedge spi_clk) begin
		if (spi_cs) begin
			if (cnt > 0) begin
				// burst just ended
				data_nibs = is_read ? cnt - rd_start : cnt - hdr_nibs;
				assert (data_nibs > 0 && data_nibs % 8 == 0) else begin
					errors++;
					$display("t=%0t chip select rose after %0d data nibbles, not whole words",
						$time, data_nibs);
				end
			end
			cnt = 0;
		end else begin
			if (cnt < 2)
				cmd_sr = {cmd_sr[3:0], spi_sout};
			else if (cnt < hdr_nibs)
				addr_sr = {addr_sr[19:0], spi_sout};
			if (cnt < hdr_nibs) begin
				assert (spi_oe) else begin
					errors++;
					$display("[FAIL] t=%0t spi_oe expected 1 got 0", $time);
				end
			end
			if (cnt == 1) begin
				assert (cmd_sr == qpimem_pkg::read_cmd || cmd_sr == qpimem_pkg::write_cmd)
				else begin
					errors++;
					$display("t=%0t unknown command %h on the bus", $time, cmd_sr);
				end
				is_read = (cmd_sr == qpimem_pkg::read_cmd);
			end
			if (cnt >= hdr_nibs && !is_read) begin
				assert (spi_oe) else begin
					errors++;
					$display("[FAIL] t=%0t spi_oe expected 1 got 0", $time);
				end
				wr_sr = {wr_sr[27:0], spi_sout};
				// word complete, store at base plus word index
				if ((cnt - hdr_nibs) % 8 == 7) begin
					wr_idx = addr_sr[7:0] + 8'((cnt - hdr_nibs) / 8);
					mem[wr_idx] = wr_sr;
				end
			end
			if (cnt >= rd_start && is_read) begin
				assert (!spi_oe) else begin
					errors++;
					$display("[FAIL] t=%0t spi_oe expected 0 got 1", $time);
				end
			end
			cnt = cnt + 1;
		end
	end

	// read nibbles go out on falling spi_clk, high nibble first
	always @(negedge spi_clk) begin
		if (is_read && cnt >= rd_start) begin
			rd_pos = cnt - rd_start;
			rd_idx = addr_sr[7:0] + 8'(rd_pos / 8);
			rd_word = mem[rd_idx];
			spi_sin <= rd_word[(7 - rd_pos % 8) * 4 +: 4];
		end else begin
			spi_sin <= 4'h0;
		end
	end

endmodule

`default_nettype wire

//--- tb_qpimem.sv
// testbench top for the qpi psram subsystem
// clock, reset, burst stimulus, scoreboard checks, timeout and summary
`default_nettype none
`timescale 1ns/100ps

module tb_qpimem;

	// ten bursts, 69 words in all
	localparam int n_bursts = 10;
	localparam int n_words = 69;
	// admission, command, address, dummies and release
	localparam int burst_cycles = 30;
	// eight wire cycles plus push and pop
	localparam int word_cycles = 12;
	localparam int hold_cycles = 40;
	localparam int max_cycles = n_bursts * burst_cycles + n_words * word_cycles +
		hold_cycles + 400;

	logic clk = 1'b0;
	logic rst;
	logic req_strobe;
	qpimem_pkg::host_req_t req;
	logic ready;
	logic done;
	logic wr_push;
	qpimem_pkg::word_t wr_data;
	logic wr_full;
	logic rd_pop;
	qpimem_pkg::rd_item_t rd_item;
	logic rd_empty;
	logic spi_clk;
	logic spi_cs;
	logic [3:0] spi_sout;
	logic [3:0] spi_sin;
	logic spi_oe;

	int errors = 0;
	int model_errors;
	int cycles = 0;
	int issued = 0;
	int done_count = 0;
	logic prev_done = 1'b0;
	// expected memory contents, low eight address bits
	qpimem_pkg::word_t mirror [256];

	always #5 clk = ~clk;

	qpimem_subsys i_qpimem_subsys (.*);

	qpi_psram_model i_psram (
		.spi_clk(spi_clk),
		.spi_cs(spi_cs),
		.spi_sout(spi_sout),
		.spi_oe(spi_oe),
		.spi_sin(spi_sin),
		.errors(model_errors)
	);

	task automatic expect_bit(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] t=%0t %s expected %0b got %0b", $time, name, exp, got);
		end
	endtask

	task automatic expect_word(input string name, input qpimem_pkg::word_t got,
		input qpimem_pkg::word_t exp);
		assert (got === exp) else begin
			errors++;
			$display("[FAIL] t=%0t %s expected %h got %h", $time, name, exp, got);
		end
	endtask

	// random words into the write fifo, mirrored by address
	task automatic push_words(input logic [23:0] addr, input int n);
		qpimem_pkg::word_t w;
		for (int i = 0; i < n; i++) begin
			w = $urandom;
			mirror[addr[7:0] + 8'(i)] = w;
			@(negedge clk);
			wr_push = 1'b1;
			wr_data = w;
		end
		@(negedge clk);
		wr_push = 1'b0;
	endtask

	task automatic send_req(input logic write, input logic [23:0] addr, input int n);
		while (!ready)
			@(negedge clk);
		req_strobe = 1'b1;
		req = '{write: write, addr: addr, nwords: n[qpimem_pkg::count_w-1:0]};
		issued++;
		@(negedge clk);
		req_strobe = 1'b0;
	endtask

	task automatic wait_bursts();
		while (done_count != issued)
			@(negedge clk);
	endtask

	task automatic pop_and_compare(input logic [23:0] addr, input int n);
		for (int i = 0; i < n; i++) begin
			while (rd_empty)
				@(negedge clk);
			expect_word("rd_item.data", rd_item.data, mirror[addr[7:0] + 8'(i)]);
			expect_bit("rd_item.last", rd_item.last, i == n - 1);
			rd_pop = 1'b1;
			@(negedge clk);
			rd_pop = 1'b0;
		end
	endtask

	task automatic read_and_compare(input logic [23:0] addr, input int n);
		send_req(1'b0, addr, n);
		wait_bursts();
		pop_and_compare(addr, n);
	endtask

	// request must stay parked, no chip select
	task automatic watch_held(input int n);
		repeat (n) begin
			@(negedge clk);
			expect_bit("ready", ready, 1'b0);
			expect_bit("spi_cs", spi_cs, 1'b1);
		end
	endtask

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout, run did not finish within %0d cycles", max_cycles);
			$display("tests failed");
			$finish;
		end
	end

	// done pulses, sampled mid cycle
	always @(negedge clk) begin
		if (!rst && done) begin
			done_count <= done_count + 1;
			expect_bit("spi_cs", spi_cs, 1'b1);
			assert (!prev_done) else begin
				errors++;
				$display("t=%0t done stayed high for more than one cycle", $time);
			end
			assert (done_count < issued) else begin
				errors++;
				$display("t=%0t done pulsed with no burst outstanding", $time);
			end
		end
		prev_done <= done;
	end

	initial begin
		void'($urandom(32'h9dc9_a348));
		rst = 1'b1;
		req_strobe = 1'b0;
		req = '0;
		wr_push = 1'b0;
		wr_data = '0;
		rd_pop = 1'b0;
		repeat (5) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);

		// idle state after reset
		expect_bit("spi_cs", spi_cs, 1'b1);
		expect_bit("spi_oe", spi_oe, 1'b0);
		expect_bit("ready", ready, 1'b1);
		expect_bit("rd_empty", rd_empty, 1'b1);
		expect_bit("wr_full", wr_full, 1'b0);

		// single word round trip
		push_words(24'h00_0a07, 1);
		send_req(1'b1, 24'h00_0a07, 1);
		wait_bursts();
		read_and_compare(24'h00_0a07, 1);

		// full burst write, reads at several offsets
		push_words(24'h12_3410, 16);
		send_req(1'b1, 24'h12_3410, 16);
		wait_bursts();
		read_and_compare(24'h12_3410, 16);
		read_and_compare(24'h12_3413, 5);
		read_and_compare(24'h12_341f, 1);

		// read fifo full, next read waits for pops
		send_req(1'b0, 24'h12_3410, 16);
		wait_bursts();
		send_req(1'b0, 24'h12_3418, 5);
		watch_held(20);
		pop_and_compare(24'h12_3410, 16);
		wait_bursts();
		pop_and_compare(24'h12_3418, 5);

		// write request ahead of its data
		send_req(1'b1, 24'h3f_0064, 4);
		watch_held(10);
		push_words(24'h3f_0064, 3);
		watch_held(5);
		push_words(24'h3f_0067, 1);
		wait_bursts();
		read_and_compare(24'h3f_0064, 4);

		// stray done pulses would show up here
		repeat (10) @(negedge clk);
		assert (done_count == issued) else begin
			errors++;
			$display("t=%0t %0d done pulses for %0d bursts", $time, done_count, issued);
		end

		$display("summary: %0d errors (testbench %0d, memory model %0d)",
			errors + model_errors, errors, model_errors);
		if (errors + model_errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- flist.f
qpimem_pkg.sv
qpimem_fifo.sv
qpimem_iface.sv
qpimem_sequencer.sv
qpimem_subsys.sv
qpi_psram_model.sv
tb_qpimem.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the qpi psram testbench with verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f flist.f \
	--top-module tb_qpimem \
	-Mdir obj_dir \
	-o tb_qpimem

./obj_dir/tb_qpimem | tee sim.log

# result comes from the log, not the exit status
if grep -qx "all tests passed" sim.log; then
	exit 0
else
	echo "simulation reported failure, see sim.log"
	exit 1
fi
